/* flist.f */
dcache_pkg.sv
dcache_ifs.sv
req_stage.sv
cache_arrays.sv
cache_ctrl.sv
mem_port.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    localparam int NUM_SETS        = 4;
    localparam int CLK_PERIOD      = 100;
    localparam int SEED            = 32'h3c69_4ba6;
    localparam int NUM_RANDOM      = 300;
    localparam int NUM_REQS        = 8 + 32 + 4 + 5 + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = 400 * NUM_REQS;
    localparam int WAIT_LIMIT      = 200;     // per handshake
    localparam int IDX_LSB         = dcache_pkg::OFFSET_W;
    localparam int TAG_LSB         = IDX_LSB + $clog2(NUM_SETS);

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    logic              req_op;
    dcache_pkg::addr_t req_addr;
    dcache_pkg::word_t req_wdata;
    dcache_pkg::strb_t req_wstrb;
    logic              req_ready;
    logic              resp_valid;
    dcache_pkg::word_t resp_rdata;
    logic              mem_rd_req;
    dcache_pkg::addr_t mem_rd_addr;
    logic              mem_rd_ready;
    logic              mem_ret_valid;
    dcache_pkg::line_t mem_ret_line;
    logic              mem_wr_req;
    dcache_pkg::addr_t mem_wr_addr;
    dcache_pkg::line_t mem_wr_line;
    logic              mem_wr_ready;
    logic              mem_wr_done;

    integer            seed;
    int                errors = 0;
    int                tests = 0;
    int                reqs = 0;
    int                rd_count = 0;
    int                wr_count = 0;
    dcache_pkg::addr_t last_rd_addr;
    dcache_pkg::addr_t last_wr_addr;
    dcache_pkg::line_t last_wr_line;
    logic [7:0]        ref_mem [dcache_pkg::addr_t];
    dcache_pkg::addr_t m_tag [2][NUM_SETS];
    bit                m_valid [2][NUM_SETS];
    bit                m_dirty [2][NUM_SETS];
    bit                m_lru [NUM_SETS];          // way to replace next
    dcache_pkg::addr_t cold_addr [4] = '{32'h0000_0000, 32'h0000_0014,
                                         32'h0000_0128, 32'h0000_1f3c};

    dcache_top #(.NUM_SETS(NUM_SETS)) i_dcache_top (.*);
    tb_mem_model #(.SEED(SEED)) i_mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory transfers as the DUT sees them
    always @(posedge clk) begin
        if (mem_rd_req && mem_rd_ready) begin
            rd_count     <= rd_count + 1;
            last_rd_addr <= mem_rd_addr;
        end
        if (mem_wr_req && mem_wr_ready) begin
            wr_count     <= wr_count + 1;
            last_wr_addr <= mem_wr_addr;
            last_wr_line <= mem_wr_line;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run exceeded %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0d ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input int num, input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    endtask

    function automatic dcache_pkg::word_t ref_word(input dcache_pkg::addr_t word_addr);
        dcache_pkg::word_t data;
        data = word_addr >> 2;    // unwritten memory holds its word address
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (ref_mem.exists(word_addr + b)) begin
                data[b*8 +: 8] = ref_mem[word_addr + b];
            end
        end
        return data;
    endfunction

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t data;
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            data[w*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = ref_word(line_addr + 4 * w);
        end
        return data;
    endfunction

    // one request, from prediction through completion and model update
    task automatic access(input logic op, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::strb_t wstrb);
        dcache_pkg::addr_t word_addr;
        dcache_pkg::addr_t line_addr;
        dcache_pkg::addr_t wb_addr;
        dcache_pkg::line_t wb_line;
        dcache_pkg::addr_t tag;
        int                idx;
        int                way;
        bit                hit;
        bit                do_wb;
        int                rd0;
        int                wr0;
        int                cycles;

        word_addr = {addr[31:2], 2'b00};
        line_addr = {addr[31:IDX_LSB], {IDX_LSB{1'b0}}};
        idx       = (addr >> IDX_LSB) % NUM_SETS;
        tag       = addr >> TAG_LSB;
        hit       = 1'b0;
        way       = 0;
        do_wb     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (!m_valid[0][idx]) begin
                way = 0;
            end else if (!m_valid[1][idx]) begin
                way = 1;
            end else begin
                way = m_lru[idx] ? 1 : 0;
            end
            do_wb   = m_valid[way][idx] && m_dirty[way][idx];
            wb_addr = (m_tag[way][idx] << TAG_LSB) | (idx << IDX_LSB);
            wb_line = ref_line(wb_addr);
        end
        rd0 = rd_count;
        wr0 = wr_count;
        reqs++;

        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        cycles    = 0;
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            report_failure("request was never accepted");
            req_valid = 1'b0;
            return;
        end
        @(negedge clk);
        req_valid = 1'b0;
        cycles    = 1;    // falling edges since acceptance
        while (!(op ? req_ready : resp_valid) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(op ? req_ready : resp_valid)) begin
            report_failure(op ? "store never finished" : "load never returned data");
            return;
        end

        if (!op && resp_rdata !== ref_word(word_addr)) begin
            report_mismatch("resp_rdata", resp_rdata, ref_word(word_addr));
        end
        // rising edges after the accepting one
        if (!op && hit && cycles - 1 != 2) begin
            report_mismatch("resp_valid latency", cycles - 1, 2);
        end
        if (rd_count - rd0 != (hit ? 0 : 1)) begin
            report_mismatch("mem_rd_req count", rd_count - rd0, hit ? 0 : 1);
        end
        if (!hit && last_rd_addr !== line_addr) begin
            report_mismatch("mem_rd_addr", last_rd_addr, line_addr);
        end
        if (wr_count - wr0 != (do_wb ? 1 : 0)) begin
            report_mismatch("mem_wr_req count", wr_count - wr0, do_wb ? 1 : 0);
        end
        if (do_wb && last_wr_addr !== wb_addr) begin
            report_mismatch("mem_wr_addr", last_wr_addr, wb_addr);
        end
        if (do_wb && last_wr_line !== wb_line) begin
            report_mismatch("mem_wr_line", last_wr_line, wb_line);
        end

        if (!hit) begin
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        if (op) begin
            m_dirty[way][idx] = 1'b1;
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (wstrb[b]) begin
                    ref_mem[word_addr + b] = wdata[b*8 +: 8];
                end
            end
        end
        m_lru[idx] = (way == 0);
    endtask

    initial begin
        logic [31:0]       rnd;
        dcache_pkg::addr_t addr;
        int                gap;
        int                test_err;
        int                mark;

        seed      = SEED;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // cold loads, then the same lines again
        test_err = errors;
        if (!req_ready || resp_valid || mem_rd_req || mem_wr_req) begin
            report_failure("outputs not idle after reset");
        end
        mark = rd_count;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 4; i++) begin
                access(1'b0, cold_addr[i], '0, '0);
            end
        end
        if (rd_count - mark != 4) begin
            report_mismatch("mem_rd_req total", rd_count - mark, 4);
        end
        finish_test(1, "cold loads", test_err);

        test_err = errors;
        for (int s = 0; s < 16; s++) begin
            rnd  = $random(seed);
            addr = 32'h0000_2000 + 4 * (s % 4);
            access(1'b1, addr, rnd, s[3:0]);
            access(1'b0, addr, '0, '0);
        end
        finish_test(2, "strobed stores", test_err);

        // set 1: two dirty lines, then a third tag
        test_err = errors;
        mark     = wr_count;
        access(1'b1, 32'h0000_0414, $random(seed), 4'hf);
        access(1'b1, 32'h0000_0458, $random(seed), 4'hf);
        access(1'b0, 32'h0000_0490, '0, '0);
        if (wr_count - mark != 1) begin
            report_mismatch("mem_wr_req count", wr_count - mark, 1);
        end
        access(1'b0, 32'h0000_0414, '0, '0);   // comes back from memory
        finish_test(3, "dirty write-back", test_err);

        // set 2: A, B, A, then C must evict B
        test_err = errors;
        access(1'b0, 32'h0000_0820, '0, '0);
        access(1'b0, 32'h0000_0860, '0, '0);
        access(1'b0, 32'h0000_0820, '0, '0);
        access(1'b0, 32'h0000_08a0, '0, '0);
        mark = rd_count;
        access(1'b0, 32'h0000_0820, '0, '0);
        if (rd_count != mark) begin
            report_mismatch("mem_rd_req count", rd_count - mark, 0);
        end
        finish_test(4, "lru replacement", test_err);

        test_err = errors;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
            rnd  = $random(seed);
            addr = $random(seed) & 32'h0000_01fc;    // 8 tags over 4 sets
            access(rnd[0], addr, $random(seed), rnd[7:4]);
        end
        finish_test(5, "random mix", test_err);

        $display("%0d tests, %0d requests, %0d errors", tests, reqs, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_rd_req,
    input  dcache_pkg::addr_t mem_rd_addr,
    output logic              mem_rd_ready,
    output logic              mem_ret_valid,
    output dcache_pkg::line_t mem_ret_line,
    input  logic              mem_wr_req,
    input  dcache_pkg::addr_t mem_wr_addr,
    input  dcache_pkg::line_t mem_wr_line,
    output logic              mem_wr_ready,
    output logic              mem_wr_done
);
    integer            seed;
    dcache_pkg::word_t store [dcache_pkg::addr_t];   // keyed by word address

    // unwritten words read back as their own word address
    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t waddr);
        if (store.exists(waddr)) begin
            return store[waddr];
        end
        return waddr;
    endfunction

    task automatic random_wait();
        int cycles;
        cycles = $unsigned($random(seed)) % 4;
        repeat (cycles) @(negedge clk);
    endtask

    initial begin
        seed          = SEED;
        mem_rd_ready  = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_line  = '0;
        mem_wr_ready  = 1'b0;
        mem_wr_done   = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && mem_wr_req) begin
                random_wait();
                mem_wr_ready = 1'b1;
                @(negedge clk);                 // taken on the edge in between
                mem_wr_ready = 1'b0;
                random_wait();
                for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                    store[(mem_wr_addr >> 2) + w] =
                        mem_wr_line[w*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
                end
                mem_wr_done = 1'b1;
                @(negedge clk);
                mem_wr_done = 1'b0;
            end else if (!reset && mem_rd_req) begin
                random_wait();
                mem_rd_ready = 1'b1;
                @(negedge clk);
                mem_rd_ready = 1'b0;
                random_wait();
                for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                    mem_ret_line[w*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
                        read_word((mem_rd_addr >> 2) + w);
                end
                mem_ret_valid = 1'b1;
                @(negedge clk);
                mem_ret_valid = 1'b0;
            end
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              reset,
    // cpu side
    input  logic              req_valid,
    input  logic              req_op,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    output logic              req_ready,
    output logic              resp_valid,
    output dcache_pkg::word_t resp_rdata,
    // memory side
    output logic              mem_rd_req,
    output dcache_pkg::addr_t mem_rd_addr,
    input  logic              mem_rd_ready,
    input  logic              mem_ret_valid,
    input  dcache_pkg::line_t mem_ret_line,
    output logic              mem_wr_req,
    output dcache_pkg::addr_t mem_wr_addr,
    output dcache_pkg::line_t mem_wr_line,
    input  logic              mem_wr_ready,
    input  logic              mem_wr_done
);
    logic              start_wb;
    logic              start_rf;
    dcache_pkg::addr_t victim_addr;
    dcache_pkg::line_t victim_line;
    dcache_pkg::addr_t refill_addr;
    logic              wb_done;
    logic              rf_done;
    dcache_pkg::line_t rf_line;

    cpu_req_if cpu_req ();
    array_if #(.NUM_SETS(NUM_SETS)) arr_bus ();

    req_stage #(.NUM_SETS(NUM_SETS)) i_req_stage (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .req_ready (req_ready),
        .cpu       (cpu_req.driver)
    );

    cache_arrays #(.NUM_SETS(NUM_SETS)) i_cache_arrays (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_bus.array)
    );

    cache_ctrl #(.NUM_SETS(NUM_SETS)) i_cache_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu_req.consumer),
        .arr         (arr_bus.ctrl),
        .start_wb    (start_wb),
        .start_rf    (start_rf),
        .victim_addr (victim_addr),
        .victim_line (victim_line),
        .refill_addr (refill_addr),
        .wb_done     (wb_done),
        .rf_done     (rf_done),
        .rf_line     (rf_line),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata)
    );

    mem_port #(.NUM_SETS(NUM_SETS)) i_mem_port (
        .clk           (clk),
        .reset         (reset),
        .start_wb      (start_wb),
        .start_rf      (start_rf),
        .victim_addr   (victim_addr),
        .victim_line   (victim_line),
        .refill_addr   (refill_addr),
        .wb_done       (wb_done),
        .rf_done       (rf_done),
        .rf_line       (rf_line),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_ready  (mem_rd_ready),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_line  (mem_ret_line),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_line   (mem_wr_line),
        .mem_wr_ready  (mem_wr_ready),
        .mem_wr_done   (mem_wr_done)
    );

endmodule

/* mem_port.sv */
`timescale 1ns/1ps

module mem_port #(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_wb,
    input  logic              start_rf,
    input  dcache_pkg::addr_t victim_addr,
    input  dcache_pkg::line_t victim_line,
    input  dcache_pkg::addr_t refill_addr,
    output logic              wb_done,
    output logic              rf_done,
    output dcache_pkg::line_t rf_line,
    output logic              mem_rd_req,
    output dcache_pkg::addr_t mem_rd_addr,
    input  logic              mem_rd_ready,
    input  logic              mem_ret_valid,
    input  dcache_pkg::line_t mem_ret_line,
    output logic              mem_wr_req,
    output dcache_pkg::addr_t mem_wr_addr,
    output dcache_pkg::line_t mem_wr_line,
    input  logic              mem_wr_ready,
    input  logic              mem_wr_done
);
    localparam int OFF_W  = dcache_pkg::OFFSET_W;
    localparam int LNUM_W = dcache_pkg::tag_w(NUM_SETS) + dcache_pkg::index_w(NUM_SETS);

    logic [LNUM_W-1:0] rd_lnum;   // line numbers, offset bits dropped
    logic [LNUM_W-1:0] wr_lnum;
    logic              rd_pend;
    logic              wr_pend;

    assign mem_rd_addr = {rd_lnum, {OFF_W{1'b0}}};
    assign mem_wr_addr = {wr_lnum, {OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wr_req <= 1'b0;
            mem_rd_req <= 1'b0;
            wr_pend    <= 1'b0;
            rd_pend    <= 1'b0;
            wb_done    <= 1'b0;
            rf_done    <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            rf_done <= 1'b0;
            if (start_wb) begin
                mem_wr_req <= 1'b1;
                wr_pend    <= 1'b1;
            end else if (mem_wr_req && mem_wr_ready) begin
                mem_wr_req <= 1'b0;
            end
            if (wr_pend && !mem_wr_req && mem_wr_done) begin
                wr_pend <= 1'b0;
                wb_done <= 1'b1;
            end
            if (start_rf) begin
                mem_rd_req <= 1'b1;
                rd_pend    <= 1'b1;
            end else if (mem_rd_req && mem_rd_ready) begin
                mem_rd_req <= 1'b0;
            end
            if (rd_pend && !mem_rd_req && mem_ret_valid) begin
                rd_pend <= 1'b0;
                rf_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_wb) begin
            wr_lnum     <= victim_addr[dcache_pkg::ADDR_W-1:OFF_W];
            mem_wr_line <= victim_line;
        end
        if (start_rf) begin
            rd_lnum <= refill_addr[dcache_pkg::ADDR_W-1:OFF_W];
        end
        if (rd_pend && mem_ret_valid) begin
            rf_line <= mem_ret_line;
        end
    end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              reset,
    cpu_req_if.consumer       cpu,
    array_if.ctrl             arr,
    output logic              start_wb,
    output logic              start_rf,
    output dcache_pkg::addr_t victim_addr,
    output dcache_pkg::line_t victim_line,
    output dcache_pkg::addr_t refill_addr,
    input  logic              wb_done,
    input  logic              rf_done,
    input  dcache_pkg::line_t rf_line,
    output logic              resp_valid,
    output dcache_pkg::word_t resp_rdata
);
    localparam int TAG_W = dcache_pkg::tag_w(NUM_SETS);
    localparam int IDX_W = dcache_pkg::index_w(NUM_SETS);
    localparam int SEL_W = $clog2(dcache_pkg::WORDS_PER_LINE);
    localparam int OFF_W = dcache_pkg::OFFSET_W;

    dcache_pkg::ctrl_state_t         state;
    dcache_pkg::ctrl_state_t         state_next;
    logic [TAG_W-1:0]                req_tag;
    logic [IDX_W-1:0]                req_index;
    logic [SEL_W-1:0]                req_sel;
    logic [dcache_pkg::NUM_WAYS-1:0] hit;
    dcache_pkg::way_t                hit_way;
    dcache_pkg::way_t                pick_way;
    dcache_pkg::way_t                victim_way;
    dcache_pkg::word_t               old_word;
    dcache_pkg::word_t               merged_word;
    logic                            finish;

    assign req_tag   = cpu.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign req_index = cpu.addr[OFF_W +: IDX_W];
    assign req_sel   = cpu.addr[OFF_W-1 -: SEL_W];

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit[w] = arr.rd_valid[w] && (arr.rd_tag[w] == req_tag);
        end
    end

    assign hit_way = hit[1];
    assign finish  = (state == dcache_pkg::LOOKUP) && (|hit);

    // empty way first, else the lru way
    assign pick_way = !arr.rd_valid[0] ? 1'b0 :
                      !arr.rd_valid[1] ? 1'b1 : arr.rd_lru;

    assign old_word = arr.rd_line[hit_way][req_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    always_comb begin
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            merged_word[b*8 +: 8] = cpu.wstrb[b] ? cpu.wdata[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::IDLE:    if (cpu.valid) state_next = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: begin
                if (|hit) begin
                    state_next = dcache_pkg::IDLE;
                end else if (arr.rd_dirty[pick_way]) begin
                    state_next = dcache_pkg::WB_REQ;
                end else begin
                    state_next = dcache_pkg::RF_REQ;
                end
            end
            dcache_pkg::WB_REQ:  state_next = dcache_pkg::WB_WAIT;
            dcache_pkg::WB_WAIT: if (wb_done) state_next = dcache_pkg::RF_REQ;
            dcache_pkg::RF_REQ:  state_next = dcache_pkg::RF_WAIT;
            dcache_pkg::RF_WAIT: if (rf_done) state_next = dcache_pkg::RF_DONE;
            dcache_pkg::RF_DONE: state_next = dcache_pkg::LOOKUP;   // reread refilled set
            default:             state_next = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= dcache_pkg::IDLE;
            victim_way <= '0;
            resp_valid <= 1'b0;
        end else begin
            state      <= state_next;
            resp_valid <= finish && !cpu.op;
            if (state == dcache_pkg::LOOKUP && !(|hit)) begin
                victim_way <= pick_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            resp_rdata <= old_word;
        end
    end

    assign cpu.done = finish;

    // array side
    assign arr.rd_en       = (state == dcache_pkg::IDLE && cpu.valid) ||
                             (state == dcache_pkg::RF_DONE);
    assign arr.rd_index    = req_index;
    assign arr.wr_index    = req_index;
    assign arr.wr_way      = (state == dcache_pkg::RF_WAIT) ? victim_way : hit_way;
    assign arr.line_we     = (state == dcache_pkg::RF_WAIT) && rf_done;
    assign arr.wr_tag      = req_tag;
    assign arr.wr_line     = rf_line;
    assign arr.word_we     = finish && cpu.op;
    assign arr.wr_word_sel = req_sel;
    assign arr.wr_word     = merged_word;
    assign arr.lru_we      = finish;
    assign arr.lru_way     = hit_way;

    // memory side, victim read data still held from the lookup
    assign start_wb    = (state == dcache_pkg::WB_REQ);
    assign start_rf    = (state == dcache_pkg::RF_REQ);
    assign victim_addr = {arr.rd_tag[victim_way], req_index, {OFF_W{1'b0}}};
    assign victim_line = arr.rd_line[victim_way];
    assign refill_addr = {req_tag, req_index, {OFF_W{1'b0}}};

endmodule

/* cache_arrays.sv */
`timescale 1ns/1ps

module cache_arrays #(
    parameter int NUM_SETS = 64
) (
    input  logic  clk,
    input  logic  reset,
    array_if.array arr
);
    localparam int TAG_W = dcache_pkg::tag_w(NUM_SETS);

    logic [TAG_W-1:0]    tag_mem  [dcache_pkg::NUM_WAYS][NUM_SETS];
    dcache_pkg::line_t   data_mem [dcache_pkg::NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits [dcache_pkg::NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_bits [dcache_pkg::NUM_WAYS];
    logic [NUM_SETS-1:0] lru_bits;    // way to replace next

    // tag and data storage
    always_ff @(posedge clk) begin
        if (arr.line_we) begin
            tag_mem[arr.wr_way][arr.wr_index]  <= arr.wr_tag;
            data_mem[arr.wr_way][arr.wr_index] <= arr.wr_line;
        end else if (arr.word_we) begin
            data_mem[arr.wr_way][arr.wr_index][arr.wr_word_sel*dcache_pkg::WORD_W +:
                                               dcache_pkg::WORD_W] <= arr.wr_word;
        end
    end

    // per-line state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '{default: '0};
            dirty_bits <= '{default: '0};
            lru_bits   <= '0;
        end else begin
            if (arr.line_we) begin
                valid_bits[arr.wr_way][arr.wr_index] <= 1'b1;
                dirty_bits[arr.wr_way][arr.wr_index] <= 1'b0;   // fresh from memory
            end else if (arr.word_we) begin
                dirty_bits[arr.wr_way][arr.wr_index] <= 1'b1;
            end
            if (arr.lru_we) begin
                lru_bits[arr.wr_index] <= ~arr.lru_way;
            end
        end
    end

    // synchronous read, outputs hold while rd_en is low
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                arr.rd_tag[w]   <= tag_mem[w][arr.rd_index];
                arr.rd_line[w]  <= data_mem[w][arr.rd_index];
                arr.rd_valid[w] <= valid_bits[w][arr.rd_index];
                arr.rd_dirty[w] <= dirty_bits[w][arr.rd_index];
            end
            arr.rd_lru <= lru_bits[arr.rd_index];
        end
    end

endmodule

/* req_stage.sv */
`timescale 1ns/1ps

module req_stage #(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  logic              req_op,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    output logic              req_ready,
    cpu_req_if.driver         cpu
);
    localparam int TAG_W = dcache_pkg::tag_w(NUM_SETS);
    localparam int IDX_W = dcache_pkg::index_w(NUM_SETS);
    localparam int SEL_W = $clog2(dcache_pkg::WORDS_PER_LINE);

    logic              held;
    logic              op_q;
    logic [TAG_W-1:0]  tag_q;
    logic [IDX_W-1:0]  index_q;
    logic [SEL_W-1:0]  sel_q;     // word within line
    dcache_pkg::word_t wdata_q;
    dcache_pkg::strb_t wstrb_q;
    logic              accept;

    assign req_ready = !held;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (cpu.done) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op;
            tag_q   <= req_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
            index_q <= req_addr[dcache_pkg::OFFSET_W +: IDX_W];
            sel_q   <= req_addr[dcache_pkg::OFFSET_W-1 -: SEL_W];
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    // word aligned toward the controller
    assign cpu.valid = held;
    assign cpu.op    = op_q;
    assign cpu.addr  = {tag_q, index_q, sel_q, 2'b00};
    assign cpu.wdata = wdata_q;
    assign cpu.wstrb = wstrb_q;

endmodule

/* dcache_ifs.sv */
`timescale 1ns/1ps

interface cpu_req_if;
    logic              valid;
    logic              op;      // 1 for store
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t wdata;
    dcache_pkg::strb_t wstrb;
    logic              done;    // held request finished

    modport driver (output valid, op, addr, wdata, wstrb, input done);
    modport consumer (input valid, op, addr, wdata, wstrb, output done);
endinterface

interface array_if #(
    parameter int NUM_SETS = 64
);
    localparam int TAG_W = dcache_pkg::tag_w(NUM_SETS);
    localparam int IDX_W = dcache_pkg::index_w(NUM_SETS);
    localparam int SEL_W = $clog2(dcache_pkg::WORDS_PER_LINE);

    // read port
    logic                              rd_en;
    logic [IDX_W-1:0]                  rd_index;
    logic [TAG_W-1:0]                  rd_tag [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::NUM_WAYS-1:0]   rd_valid;
    logic [dcache_pkg::NUM_WAYS-1:0]   rd_dirty;
    dcache_pkg::line_t                 rd_line [dcache_pkg::NUM_WAYS];
    dcache_pkg::way_t                  rd_lru;

    // write port, shared by refill and store
    dcache_pkg::way_t                  wr_way;
    logic [IDX_W-1:0]                  wr_index;
    logic                              line_we;
    logic [TAG_W-1:0]                  wr_tag;
    dcache_pkg::line_t                 wr_line;
    logic                              word_we;
    logic [SEL_W-1:0]                  wr_word_sel;
    dcache_pkg::word_t                 wr_word;
    logic                              lru_we;
    dcache_pkg::way_t                  lru_way;   // way just used

    modport ctrl (
        output rd_en, rd_index, wr_way, wr_index, line_we, wr_tag, wr_line,
        output word_we, wr_word_sel, wr_word, lru_we, lru_way,
        input  rd_tag, rd_valid, rd_dirty, rd_line, rd_lru
    );

    modport array (
        input  rd_en, rd_index, wr_way, wr_index, line_we, wr_tag, wr_line,
        input  word_we, wr_word_sel, wr_word, lru_we, lru_way,
        output rd_tag, rd_valid, rd_dirty, rd_line, rd_lru
    );
endinterface

/* dcache_pkg.sv */
package dcache_pkg;

    localparam int WORD_W         = 32;
    localparam int ADDR_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;    // 128
    localparam int STRB_W         = WORD_W / 8;
    localparam int NUM_WAYS       = 2;                          // one lru bit per set
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE * STRB_W);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;     // word 0 in the low bits
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // miss handling runs WB_* only for a dirty victim
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        RF_REQ,
        RF_WAIT,
        RF_DONE
    } ctrl_state_t;

    function automatic int index_w(input int num_sets);
        return $clog2(num_sets);
    endfunction

    function automatic int tag_w(input int num_sets);
        return ADDR_W - OFFSET_W - $clog2(num_sets);
    endfunction

endpackage
